// File: design/axis_defines.svh
`ifndef AXIS_DEFINES_SVH
`define AXIS_DEFINES_SVH

// Byte wide stream, so no tkeep is carried
`define AXIS_DATA_WIDTH 8

// Bit 0 set on the tlast beat marks the frame bad
`define AXIS_USER_WIDTH 1

// Beats per port FIFO, power of two
// A frame longer than this is oversize and dropped
`define AXIS_FIFO_DEPTH 16

// Input ports and width of the port index on tid
`define AXIS_PORTS      2
`define AXIS_PORT_WIDTH 1

`endif

// File: design/axis_pkg.sv
`include "axis_defines.svh"

package axis_pkg;

    // One beat of stream data
    typedef logic [`AXIS_DATA_WIDTH-1:0] axis_data_t;

    // Sideband user bits, bad frame marker in bit 0
    typedef logic [`AXIS_USER_WIDTH-1:0] axis_user_t;

    // Source port index, driven out on tid
    typedef logic [`AXIS_PORT_WIDTH-1:0] axis_port_t;

    // FIFO pointer or beat count
    // Extra MSB tells full from empty
    typedef logic [$clog2(`AXIS_FIFO_DEPTH):0] axis_count_t;

endpackage

// File: design/axis_frame_fifo.sv
`timescale 1ns/10ps
`include "axis_defines.svh"

module axis_frame_fifo (
    input  logic                 clk,
    input  logic                 rst,

    // Input stream
    input  axis_pkg::axis_data_t s_axis_tdata,
    input  logic                 s_axis_tvalid,
    output logic                 s_axis_tready,
    input  logic                 s_axis_tlast,
    input  axis_pkg::axis_user_t s_axis_tuser,

    // Output stream, whole committed frames only
    output axis_pkg::axis_data_t m_axis_tdata,
    output logic                 m_axis_tvalid,
    input  logic                 m_axis_tready,
    output logic                 m_axis_tlast,

    // One cycle pulses after each tlast
    output logic                 status_overflow,
    output logic                 status_bad_frame,
    output logic                 status_good_frame
);

    localparam int ADDR_WIDTH = $clog2(`AXIS_FIFO_DEPTH);
    localparam axis_pkg::axis_count_t DEPTH = axis_pkg::axis_count_t'(`AXIS_FIFO_DEPTH);
    localparam axis_pkg::axis_count_t STEP = axis_pkg::axis_count_t'(1);

    // Storage word is {tlast, tdata}
    logic [`AXIS_DATA_WIDTH:0] mem [`AXIS_FIFO_DEPTH];

    // Write pointer runs ahead of the committed pointer inside a frame
    axis_pkg::axis_count_t wr_ptr;
    axis_pkg::axis_count_t wr_ptr_commit;
    axis_pkg::axis_count_t rd_ptr;
    // Beats of the current frame held in memory
    axis_pkg::axis_count_t frame_cnt;

    // Current frame went past the depth, rest of it is swallowed
    logic drop_frame;
    logic full;
    logic beyond_depth;
    logic s_fire;
    logic store_beat;
    logic commit_ready;
    logic out_load;

    // Full against the read side, so committed frames count too
    assign full = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                  (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    // Frame already holds DEPTH beats, or is being dropped
    assign beyond_depth = drop_frame || (frame_cnt == DEPTH);

    // Stall only a frame that may still fit
    assign s_axis_tready = !full || beyond_depth;
    assign s_fire = s_axis_tvalid && s_axis_tready;
    assign store_beat = s_fire && !beyond_depth;

    // Read side sees committed beats only
    assign commit_ready = (rd_ptr != wr_ptr_commit);
    assign out_load = commit_ready && (!m_axis_tvalid || m_axis_tready);

    // Beat storage
    always_ff @(posedge clk) begin
        if (store_beat) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= {s_axis_tlast, s_axis_tdata};
        end
    end

    // Write side, commit and drop control
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr            <= '0;
            wr_ptr_commit     <= '0;
            frame_cnt         <= '0;
            drop_frame        <= 1'b0;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            // Pulses default low
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;

            if (s_fire) begin
                if (s_axis_tlast) begin
                    frame_cnt  <= '0;
                    drop_frame <= 1'b0;
                    if (beyond_depth) begin
                        // Oversize wins over a bad marker
                        wr_ptr          <= wr_ptr_commit;
                        status_overflow <= 1'b1;
                    end else if (s_axis_tuser[0]) begin
                        // Bad frame, throw away everything since the last commit
                        wr_ptr           <= wr_ptr_commit;
                        status_bad_frame <= 1'b1;
                    end else begin
                        // Good frame, tlast beat included in the commit
                        wr_ptr            <= wr_ptr + STEP;
                        wr_ptr_commit     <= wr_ptr + STEP;
                        status_good_frame <= 1'b1;
                    end
                end else if (beyond_depth) begin
                    // Past the depth, free the partial frame right away
                    drop_frame <= 1'b1;
                    wr_ptr     <= wr_ptr_commit;
                end else begin
                    wr_ptr    <= wr_ptr + STEP;
                    frame_cnt <= frame_cnt + STEP;
                end
            end
        end
    end

    // Read pointer and output valid
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr        <= '0;
            m_axis_tvalid <= 1'b0;
        end else if (out_load) begin
            rd_ptr        <= rd_ptr + STEP;
            m_axis_tvalid <= 1'b1;
        end else if (m_axis_tready) begin
            m_axis_tvalid <= 1'b0;
        end
    end

    // Registered memory read
    always_ff @(posedge clk) begin
        if (out_load) begin
            {m_axis_tlast, m_axis_tdata} <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
    end

    // Whole frame is stored before its first beat leaves
    // so valid may only drop after tlast is taken
    frame_valid_held: assert property (@(posedge clk) disable iff (rst)
        m_axis_tvalid && !(m_axis_tready && m_axis_tlast) |=> m_axis_tvalid)
        else $error("m_axis_tvalid fell inside a frame");

    // A frame past the depth is drained without back-pressure until tlast
    drop_ready_held: assert property (@(posedge clk) disable iff (rst)
        s_axis_tvalid && s_axis_tready && !s_axis_tlast && beyond_depth |=> s_axis_tready)
        else $error("s_axis_tready low while dropping a frame");

endmodule

// File: design/axis_frame_arb.sv
`timescale 1ns/10ps
`include "axis_defines.svh"

module axis_frame_arb (
    input  logic                                   clk,
    input  logic                                   rst,

    // Per-port streams from the frame FIFOs
    input  axis_pkg::axis_data_t [`AXIS_PORTS-1:0] s_axis_tdata,
    input  logic [`AXIS_PORTS-1:0]                 s_axis_tvalid,
    output logic [`AXIS_PORTS-1:0]                 s_axis_tready,
    input  logic [`AXIS_PORTS-1:0]                 s_axis_tlast,

    // Merged stream with the source port on tid
    output axis_pkg::axis_data_t                   m_axis_tdata,
    output logic                                   m_axis_tvalid,
    input  logic                                   m_axis_tready,
    output logic                                   m_axis_tlast,
    output axis_pkg::axis_port_t                   m_axis_tid
);

    // Port 0 gets the first turn after reset
    localparam axis_pkg::axis_port_t LAST_INIT = axis_pkg::axis_port_t'(`AXIS_PORTS - 1);

    // Port owning the frame in flight
    axis_pkg::axis_port_t grant;
    // Port that finished the most recent frame
    axis_pkg::axis_port_t last_port;
    // Round-robin choice for the next frame
    axis_pkg::axis_port_t pick_port;
    axis_pkg::axis_port_t cur_port;

    // Between first beat and tlast of a granted frame
    logic frame_active;
    logic pick_valid;
    logic cur_valid;
    logic out_ready;
    logic take;

    // Round-robin search starting after last_port
    // last_port itself comes last, so it may go again when alone
    always_comb begin
        int unsigned idx;
        pick_port  = last_port;
        pick_valid = 1'b0;
        // Lowest k has priority, so scan downward and let it override
        for (int k = `AXIS_PORTS; k >= 1; k--) begin
            idx = (int'(last_port) + k) % `AXIS_PORTS;
            if (s_axis_tvalid[idx]) begin
                pick_port  = axis_pkg::axis_port_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    // Grant is held for the whole frame and re-picked only between frames
    assign cur_port  = frame_active ? grant : pick_port;
    assign cur_valid = frame_active ? s_axis_tvalid[grant] : pick_valid;

    // Output register empty or draining this cycle
    assign out_ready = !m_axis_tvalid || m_axis_tready;
    assign take = cur_valid && out_ready;

    // Ready goes back to the selected port only
    always_comb begin
        s_axis_tready = '0;
        s_axis_tready[cur_port] = out_ready;
    end

    // Grant state and output valid
    always_ff @(posedge clk) begin
        if (rst) begin
            grant         <= '0;
            last_port     <= LAST_INIT;
            frame_active  <= 1'b0;
            m_axis_tvalid <= 1'b0;
        end else begin
            if (take) begin
                m_axis_tvalid <= 1'b1;
                grant         <= cur_port;
                frame_active  <= !s_axis_tlast[cur_port];
                // Finished frame hands priority to the other port
                if (s_axis_tlast[cur_port]) begin
                    last_port <= cur_port;
                end
            end else if (m_axis_tready) begin
                m_axis_tvalid <= 1'b0;
            end
        end
    end

    // Output payload register
    always_ff @(posedge clk) begin
        if (take) begin
            m_axis_tdata <= s_axis_tdata[cur_port];
            m_axis_tlast <= s_axis_tlast[cur_port];
            m_axis_tid   <= cur_port;
        end
    end

    // Stalled beat held until the sink takes it
    out_beat_stable: assert property (@(posedge clk) disable iff (rst)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tlast) &&
            $stable(m_axis_tid))
        else $error("Output beat changed under back-pressure");

    // Beats taken inside a frame come from the port that sent its earlier beats
    grant_held: assert property (@(posedge clk) disable iff (rst)
        take && frame_active |-> cur_port == m_axis_tid)
        else $error("Beat from another port taken while a frame was active");

endmodule

// File: design/axis_frame_merge.sv
`timescale 1ns/10ps
`include "axis_defines.svh"

module axis_frame_merge (
    input  logic                                   clk,
    input  logic                                   rst,

    // Input streams, one slice per port
    input  axis_pkg::axis_data_t [`AXIS_PORTS-1:0] s_axis_tdata,
    input  logic [`AXIS_PORTS-1:0]                 s_axis_tvalid,
    output logic [`AXIS_PORTS-1:0]                 s_axis_tready,
    input  logic [`AXIS_PORTS-1:0]                 s_axis_tlast,
    input  axis_pkg::axis_user_t [`AXIS_PORTS-1:0] s_axis_tuser,

    // Merged output stream
    output axis_pkg::axis_data_t                   m_axis_tdata,
    output logic                                   m_axis_tvalid,
    input  logic                                   m_axis_tready,
    output logic                                   m_axis_tlast,
    output axis_pkg::axis_port_t                   m_axis_tid,

    // Per-port status pulses
    output logic [`AXIS_PORTS-1:0]                 status_overflow,
    output logic [`AXIS_PORTS-1:0]                 status_bad_frame,
    output logic [`AXIS_PORTS-1:0]                 status_good_frame
);

    // FIFO to arbiter streams
    axis_pkg::axis_data_t [`AXIS_PORTS-1:0] fifo_tdata;
    logic [`AXIS_PORTS-1:0] fifo_tvalid;
    logic [`AXIS_PORTS-1:0] fifo_tready;
    logic [`AXIS_PORTS-1:0] fifo_tlast;

    // One frame FIFO per input port
    for (genvar i = 0; i < `AXIS_PORTS; i++) begin : g_port
        axis_frame_fifo fifo_inst (
            .clk               (clk),
            .rst               (rst),
            .s_axis_tdata      (s_axis_tdata[i]),
            .s_axis_tvalid     (s_axis_tvalid[i]),
            .s_axis_tready     (s_axis_tready[i]),
            .s_axis_tlast      (s_axis_tlast[i]),
            .s_axis_tuser      (s_axis_tuser[i]),
            .m_axis_tdata      (fifo_tdata[i]),
            .m_axis_tvalid     (fifo_tvalid[i]),
            .m_axis_tready     (fifo_tready[i]),
            .m_axis_tlast      (fifo_tlast[i]),
            .status_overflow   (status_overflow[i]),
            .status_bad_frame  (status_bad_frame[i]),
            .status_good_frame (status_good_frame[i])
        );
    end

    // Frame merge onto the single output
    axis_frame_arb arb_inst (
        .clk           (clk),
        .rst           (rst),
        .s_axis_tdata  (fifo_tdata),
        .s_axis_tvalid (fifo_tvalid),
        .s_axis_tready (fifo_tready),
        .s_axis_tlast  (fifo_tlast),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tid    (m_axis_tid)
    );

endmodule

// File: dv/axis_frame_merge_tb.sv
`timescale 1ns/10ps
`include "axis_defines.svh"

module axis_frame_merge_tb;

    // Random frames per port, lengths 1 to MAX_LEN
    localparam int FRAMES = 40;
    localparam int MAX_LEN = 20;
    // Fairness phase, short good frames that all fit in one FIFO
    localparam int FAIR_FRAMES = 3;
    localparam int FAIR_LEN = 4;
    // Output ready modes
    localparam int READY_RANDOM = 0;
    localparam int READY_LOW = 1;
    localparam int READY_HIGH = 2;

    logic clk;
    logic rst;
    axis_pkg::axis_data_t [`AXIS_PORTS-1:0] s_axis_tdata;
    logic [`AXIS_PORTS-1:0] s_axis_tvalid;
    logic [`AXIS_PORTS-1:0] s_axis_tready;
    logic [`AXIS_PORTS-1:0] s_axis_tlast;
    axis_pkg::axis_user_t [`AXIS_PORTS-1:0] s_axis_tuser;
    axis_pkg::axis_data_t m_axis_tdata;
    logic m_axis_tvalid;
    logic m_axis_tready;
    logic m_axis_tlast;
    axis_pkg::axis_port_t m_axis_tid;
    logic [`AXIS_PORTS-1:0] status_overflow;
    logic [`AXIS_PORTS-1:0] status_bad_frame;
    logic [`AXIS_PORTS-1:0] status_good_frame;

    // Expected output beats per port as {tlast, tdata}
    logic [`AXIS_DATA_WIDTH:0] exp_q [`AXIS_PORTS][$];
    // Source port of each output frame, in order of completion
    axis_pkg::axis_port_t done_tids [$];
    int frame_len [`AXIS_PORTS][FRAMES];
    // Model frame counts and observed status pulses
    int exp_good [`AXIS_PORTS];
    int exp_bad [`AXIS_PORTS];
    int exp_ovf [`AXIS_PORTS];
    int seen_good [`AXIS_PORTS];
    int seen_bad [`AXIS_PORTS];
    int seen_ovf [`AXIS_PORTS];
    int errors;
    int checks;
    int total_beats;
    int ready_mode;
    // Output frame in progress and its tid
    logic in_frame;
    axis_pkg::axis_port_t frame_tid;

    axis_frame_merge UUT (
        .clk               (clk),
        .rst               (rst),
        .s_axis_tdata      (s_axis_tdata),
        .s_axis_tvalid     (s_axis_tvalid),
        .s_axis_tready     (s_axis_tready),
        .s_axis_tlast      (s_axis_tlast),
        .s_axis_tuser      (s_axis_tuser),
        .m_axis_tdata      (m_axis_tdata),
        .m_axis_tvalid     (m_axis_tvalid),
        .m_axis_tready     (m_axis_tready),
        .m_axis_tlast      (m_axis_tlast),
        .m_axis_tid        (m_axis_tid),
        .status_overflow   (status_overflow),
        .status_bad_frame  (status_bad_frame),
        .status_good_frame (status_good_frame)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic int pending_beats();
        int sum;
        sum = 0;
        for (int p = 0; p < `AXIS_PORTS; p++) begin
            sum += exp_q[p].size();
        end
        return sum;
    endfunction

    // Called at posedge+2, returns at posedge+2 after the beat is taken
    // Ready is sampled at the falling edge where it is settled
    task automatic wait_accept(input int p);
        logic accepted;
        accepted = 1'b0;
        while (!accepted) begin
            @(negedge clk);
            accepted = s_axis_tready[p];
            @(posedge clk);
            #2;
        end
    endtask

    // One frame on port p, tuser on the last beat carries the bad marker
    task automatic send_frame(input int p, input int len, input logic bad);
        logic [`AXIS_DATA_WIDTH:0] beats [$];
        axis_pkg::axis_data_t data;
        logic last_beat;
        for (int i = 0; i < len; i++) begin
            data = axis_pkg::axis_data_t'($urandom);
            last_beat = (i == len - 1);
            beats.push_back({last_beat, data});
            s_axis_tdata[p] = data;
            s_axis_tlast[p] = last_beat;
            // Middle beats get random tuser, only the last one counts
            s_axis_tuser[p] = last_beat ? axis_pkg::axis_user_t'(bad)
                                        : axis_pkg::axis_user_t'($urandom);
            s_axis_tvalid[p] = 1'b1;
            wait_accept(p);
        end
        s_axis_tvalid[p] = 1'b0;
        s_axis_tlast[p] = 1'b0;
        // Oversize is judged before the bad marker
        if (len > `AXIS_FIFO_DEPTH) begin
            exp_ovf[p]++;
        end else if (bad) begin
            exp_bad[p]++;
        end else begin
            exp_good[p]++;
            foreach (beats[i]) begin
                exp_q[p].push_back(beats[i]);
            end
        end
    endtask

    task automatic run_port(input int p);
        for (int i = 0; i < FRAMES; i++) begin
            send_frame(p, frame_len[p][i], $urandom_range(3, 0) == 0);
            // Short idle gap, sometimes none
            repeat ($urandom_range(2, 0)) begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    task automatic drive_ready();
        forever begin
            @(posedge clk);
            #2;
            if (ready_mode == READY_RANDOM) begin
                m_axis_tready = ($urandom_range(1, 0) == 1);
            end else begin
                m_axis_tready = (ready_mode == READY_HIGH);
            end
        end
    endtask

    task automatic check_beat();
        logic [`AXIS_DATA_WIDTH:0] exp_beat;
        int p;
        p = int'(m_axis_tid);
        // No interleave, tid fixed inside a frame
        if (in_frame) begin
            compare_value("m_axis_tid", 32'(m_axis_tid), 32'(frame_tid));
        end
        checks++;
        assert (exp_q[p].size() > 0) else begin
            errors++;
            $display("Output beat tagged with port %0d while no frame was expected", p);
        end
        if (exp_q[p].size() > 0) begin
            exp_beat = exp_q[p].pop_front();
            compare_value("m_axis_tdata", 32'(m_axis_tdata),
                          32'(exp_beat[`AXIS_DATA_WIDTH-1:0]));
            compare_value("m_axis_tlast", 32'(m_axis_tlast),
                          32'(exp_beat[`AXIS_DATA_WIDTH]));
        end
        in_frame = !m_axis_tlast;
        frame_tid = m_axis_tid;
        if (m_axis_tlast) begin
            done_tids.push_back(m_axis_tid);
        end
    endtask

    // Output and status pulses, sampled on the falling edge
    task automatic watch_output();
        forever begin
            @(negedge clk);
            for (int p = 0; p < `AXIS_PORTS; p++) begin
                if (status_good_frame[p]) seen_good[p]++;
                if (status_bad_frame[p]) seen_bad[p]++;
                if (status_overflow[p]) seen_ovf[p]++;
            end
            if (m_axis_tvalid && m_axis_tready) begin
                check_beat();
            end
        end
    endtask

    task automatic wait_drain();
        do begin
            @(negedge clk);
        end while (pending_beats() != 0);
        // Let late status pulses of dropped frames land
        repeat (4) @(negedge clk);
    endtask

    initial begin
        void'($urandom(32'h8e3c027f));
        rst = 1'b1;
        s_axis_tdata = '0;
        s_axis_tvalid = '0;
        s_axis_tlast = '0;
        s_axis_tuser = '0;
        m_axis_tready = 1'b0;
        ready_mode = READY_HIGH;
        errors = 0;
        checks = 0;
        total_beats = 0;
        in_frame = 1'b0;
        frame_tid = '0;
        for (int p = 0; p < `AXIS_PORTS; p++) begin
            exp_good[p] = 0;
            exp_bad[p] = 0;
            exp_ovf[p] = 0;
            seen_good[p] = 0;
            seen_bad[p] = 0;
            seen_ovf[p] = 0;
            // Lengths drawn up front so the watchdog knows the test length
            for (int i = 0; i < FRAMES; i++) begin
                frame_len[p][i] = $urandom_range(MAX_LEN, 1);
                total_beats += frame_len[p][i];
            end
        end
        total_beats += `AXIS_PORTS * FAIR_FRAMES * FAIR_LEN;
        fork
            drive_ready();
        join_none
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        // Idle state after reset
        @(negedge clk);
        compare_value("m_axis_tvalid", 32'(m_axis_tvalid), 32'h0);
        compare_value("s_axis_tready", 32'(s_axis_tready), 32'((1 << `AXIS_PORTS) - 1));
        compare_value("status_overflow", 32'(status_overflow), 32'h0);
        compare_value("status_bad_frame", 32'(status_bad_frame), 32'h0);
        compare_value("status_good_frame", 32'(status_good_frame), 32'h0);
        fork
            watch_output();
        join_none

        // Random frames on both ports under random back-pressure
        ready_mode = READY_RANDOM;
        @(posedge clk);
        #2;
        fork
            run_port(0);
            run_port(1);
        join
        wait_drain();

        // Fairness, frames pile up behind a stalled output
        ready_mode = READY_LOW;
        done_tids.delete();
        @(posedge clk);
        #2;
        fork
            begin
                for (int i = 0; i < FAIR_FRAMES; i++) send_frame(0, FAIR_LEN, 1'b0);
            end
            begin
                for (int i = 0; i < FAIR_FRAMES; i++) send_frame(1, FAIR_LEN, 1'b0);
            end
        join
        repeat (4) @(negedge clk);
        ready_mode = READY_HIGH;
        wait_drain();
        checks++;
        assert (done_tids.size() == 2 * FAIR_FRAMES) else begin
            errors++;
            $display("Fairness phase produced %0d frames instead of %0d",
                     done_tids.size(), 2 * FAIR_FRAMES);
        end
        for (int i = 1; i < done_tids.size(); i++) begin
            checks++;
            assert (done_tids[i] != done_tids[i-1]) else begin
                errors++;
                $display("Output frames %0d and %0d both came from port %0d",
                         i - 1, i, done_tids[i]);
            end
        end

        // Status pulse totals against the model
        for (int p = 0; p < `AXIS_PORTS; p++) begin
            compare_value($sformatf("status_good_frame[%0d] pulses", p),
                          32'(seen_good[p]), 32'(exp_good[p]));
            compare_value($sformatf("status_bad_frame[%0d] pulses", p),
                          32'(seen_bad[p]), 32'(exp_bad[p]));
            compare_value($sformatf("status_overflow[%0d] pulses", p),
                          32'(seen_ovf[p]), 32'(exp_ovf[p]));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Budget of 40 cycles per stimulus beat plus margin
    initial begin
        #1;
        repeat (total_beats * 40 + 2000) @(posedge clk);
        $display("Watchdog expired, the output did not drain within %0d beats of budget",
                 total_beats);
        $display("Checks: %0d, errors: %0d", checks, errors);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+design
design/axis_pkg.sv
design/axis_frame_fifo.sv
design/axis_frame_arb.sv
design/axis_frame_merge.sv
dv/axis_frame_merge_tb.sv

// File: Makefile
TOP := axis_frame_merge_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -f compile.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
